/* Makefile */
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

/* compile.f */
+incdir+hdl
hdl/rvCorePkg.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/aluExec.sv
hdl/storeCreditPort.sv
hdl/rvCoreTop.sv
dv/rvCoreTb.sv

/* dv/rvCoreTb.sv */
`timescale 1ns/1ps
`include "rvCoreConsts.svh"

module rvCoreTb;
    import rvCorePkg::*;

    localparam int MainLen = 22;
    localparam int BadLen  = 3;

    logic             clk = 1'b0;
    logic             reset;
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
    logic             storeValid;
    logic [`XLEN-1:0] storeAddr;
    logic [`XLEN-1:0] storeData;
    logic             storeCredit;
    logic             halted;
    logic             illegal;

    logic [31:0]      imem [0:31];
    logic [`XLEN-1:0] fetchOffset;
    int               progLen = 0;
    int               storeBase = 0; // first expected store of the running program
    int               storeLimit = 0;
    int               storeIdx = 0;
    int               pending = 0;   // issued and not yet credited
    logic             creditOn = 1'b0;
    integer           seed = 32'h93dfcdf1;
    integer           coin;

    // main program at 0..21, illegal program at 22..24
    logic [31:0] progTable [0:24] = '{
        32'hFFB0_0093, // addi x1, x0, -5
        32'h8000_0137, // lui x2, 0x80000
        32'h0000_1197, // auipc x3, 0x1
        32'h0240_9213, // slli x4, x1, 36
        32'h2000_0293, // addi x5, x0, 0x200
        32'h0012_B023, // sd x1, 0(x5)
        32'h0022_B423, // sd x2, 8(x5)
        32'hFE32_BC23, // sd x3, -8(x5)
        32'h0042_B823, // sd x4, 16(x5)
        32'h00C0_036F, // jal x6, +12
        32'h0012_BC23, // skipped
        32'h0212_B023, // skipped
        32'h0062_BC23, // sd x6, 24(x5), stalls without credit
        32'h0000_0397, // auipc x7, 0
        32'h0113_8467, // jalr x8, 17(x7)
        32'h0012_BC23, // skipped
        32'h0212_B023, // skipped
        32'h0282_B023, // sd x8, 32(x5)
        32'hFFF0_8493, // addi x9, x1, -1
        32'h0292_B423, // sd x9, 40(x5)
        32'h0010_0073, // ebreak
        32'h0012_B023, // never reached
        32'h2000_0293, // addi x5, x0, 0x200
        32'h0052_B023, // sd x5, 0(x5)
        32'h0052_83B3  // add x7, x5, x5 is outside the subset
    };

    // {address, data} of each store in issue order
    logic [2*`XLEN-1:0] expStores [0:7] = '{
        {64'h0000_0000_0000_0200, 64'hFFFF_FFFF_FFFF_FFFB},
        {64'h0000_0000_0000_0208, 64'hFFFF_FFFF_8000_0000},
        {64'h0000_0000_0000_01F8, 64'h0000_0000_8000_1008},
        {64'h0000_0000_0000_0210, 64'hFFFF_FFB0_0000_0000},
        {64'h0000_0000_0000_0218, 64'h0000_0000_8000_0028}, // jal link
        {64'h0000_0000_0000_0220, 64'h0000_0000_8000_003C}, // jalr link
        {64'h0000_0000_0000_0228, 64'hFFFF_FFFF_FFFF_FFFA},
        {64'h0000_0000_0000_0200, 64'h0000_0000_0000_0200}
    };

    rvCoreTop dut0 (.clk, .reset, .pc, .inst, .storeValid, .storeAddr, .storeData,
                    .storeCredit, .halted, .illegal);

    always #2 clk = ~clk;

    assign fetchOffset = (pc - `RESET_PC) >> 2;

    always_comb begin
        if (fetchOffset < 64'(progLen)) begin
            inst = imem[fetchOffset[4:0]];
        end else begin
            inst = 32'h0; // off the end reads as illegal
        end
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic [`XLEN-1:0] expected,
                             input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("CHECK FAILED %s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            reportFailure($sformatf("CHECK FAILED %s expected %b actual %b",
                                    name, expected, actual));
        end
    endtask

    task automatic waitStores(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (storeIdx < target) begin
            if (cycles == limit) begin
                reportFailure($sformatf("timed out waiting for %0d stores", target));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic waitPc(input logic [`XLEN-1:0] target, input int limit);
        int cycles;
        cycles = 0;
        while (pc !== target) begin
            if (cycles == limit) begin
                reportFailure($sformatf("timed out waiting for pc %h", target));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic waitHalt(input int limit);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles == limit) begin
                reportFailure("timed out waiting for the core to halt");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // loads a program from the table while the core sits in reset
    task automatic applyReset(input int start, input int len, input int base, input int limit);
        @(posedge clk);
        #1;
        reset = 1'b1;
        creditOn = 1'b0;
        for (int i = 0; i < len; i++) begin
            imem[i] = progTable[start + i];
        end
        progLen = len;
        storeBase = base;
        storeLimit = limit;
        storeIdx = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // memory side returns credits at random
    always @(posedge clk) begin
        #1;
        coin = $random(seed);
        storeCredit = creditOn && pending > 0 && coin[0];
    end

    // store monitor, outputs settled mid cycle
    always @(negedge clk) begin
        if (reset) begin
            pending = 0;
        end else begin
            if (storeValid && storeIdx >= storeLimit) begin
                reportFailure($sformatf("unexpected store to %h after the last one", storeAddr));
            end else if (storeValid) begin
                checkWord($sformatf("store %0d address", storeIdx),
                          expStores[storeBase + storeIdx][2*`XLEN-1:`XLEN], storeAddr);
                checkWord($sformatf("store %0d data", storeIdx),
                          expStores[storeBase + storeIdx][`XLEN-1:0], storeData);
                storeIdx++;
            end
            pending = pending + (storeValid ? 1 : 0) - (storeCredit ? 1 : 0);
            if (pending > `STORE_CREDITS) begin
                reportFailure("more stores outstanding than the core has credits");
            end
        end
    end

    initial begin
        reset = 1'b1;
        storeCredit = 1'b0;
        applyReset(0, MainLen, 0, 7);
        @(negedge clk);
        checkWord("reset pc", `RESET_PC, pc);
        checkFlag("reset storeValid", 1'b0, storeValid);
        checkFlag("reset halted", 1'b0, halted);
        checkFlag("reset illegal", 1'b0, illegal);

        // credits held back, the fifth sd must stall
        waitStores(`STORE_CREDITS, 100);
        waitPc(64'h8000_0030, 50);
        repeat (10) @(negedge clk);
        checkWord("stalled pc", 64'h8000_0030, pc);
        checkWord("stores while stalled", `STORE_CREDITS, 64'(storeIdx));
        checkFlag("halted while stalled", 1'b0, halted);

        creditOn = 1'b1;
        waitStores(7, 400);
        waitHalt(50);
        checkFlag("illegal after ebreak", 1'b0, illegal);
        checkWord("pc after ebreak", 64'h8000_0054, pc);
        repeat (20) @(negedge clk);
        checkWord("frozen pc", 64'h8000_0054, pc);
        checkFlag("halted stays high", 1'b1, halted);

        applyReset(MainLen, BadLen, 7, 1);
        waitHalt(100);
        checkFlag("illegal flag", 1'b1, illegal);
        checkWord("pc after illegal", 64'h8000_000C, pc);
        checkWord("stores in second program", 64'd1, 64'(storeIdx));

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* hdl/aluExec.sv */
`timescale 1ns/1ps
`include "rvCoreConsts.svh"

module aluExec (
    input  rvCorePkg::aluOpT  aluOp,
    input  rvCorePkg::aluSrcT aluSrc,
    input  logic [`XLEN-1:0]  rs1Data,
    input  logic [`XLEN-1:0]  rs2Data,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  result
);
    import rvCorePkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] sum;

    // operand pair select
    always_comb begin
        case (aluSrc)
            srcRs1Imm: begin
                opA = rs1Data;
                opB = imm;
            end
            srcImmPc: begin
                opA = imm;
                opB = pc;
            end
            default: begin // srcRs1Rs2
                opA = rs1Data;
                opB = rs2Data;
            end
        endcase
    end

    assign sum = opA + opB;

    always_comb begin
        case (aluOp)
            aluAdd:         result = sum;
            aluAddClearLsb: result = {sum[`XLEN-1:1], 1'b0}; // jalr drops bit 0
            aluShiftLeft:   result = opA << opB[5:0];        // rv64 shamt is 6 bits
            default:        result = '0;
        endcase
    end

endmodule

/* hdl/instDecoder.sv */
`timescale 1ns/1ps
`include "rvCoreConsts.svh"

module instDecoder (
    input  logic [31:0]          inst,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd,
    output logic [`XLEN-1:0]     imm,
    output rvCorePkg::aluOpT     aluOp,
    output rvCorePkg::aluSrcT    aluSrc,
    output rvCorePkg::regSrcT    regSrc,
    output rvCorePkg::pcSrcT     pcSrc,
    output logic                 isStore,
    output logic                 isBreak,
    output logic                 isIllegal
);
    import rvCorePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    function automatic logic [`XLEN-1:0] immI(input logic [31:0] word);
        return {{(`XLEN-12){word[31]}}, word[31:20]};
    endfunction

    function automatic logic [`XLEN-1:0] immS(input logic [31:0] word);
        return {{(`XLEN-12){word[31]}}, word[31:25], word[11:7]};
    endfunction

    function automatic logic [`XLEN-1:0] immU(input logic [31:0] word);
        return {{(`XLEN-32){word[31]}}, word[31:12], 12'b0};
    endfunction

    function automatic logic [`XLEN-1:0] immJ(input logic [31:0] word);
        return {{(`XLEN-21){word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // register fields sit at fixed positions for every format
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        // anything not matched below ends up illegal with no side effects
        imm       = '0;
        aluOp     = aluNone;
        aluSrc    = srcRs1Rs2;
        regSrc    = regNone;
        pcSrc     = pcSnpc;
        isStore   = 1'b0;
        isBreak   = 1'b0;
        isIllegal = 1'b1;
        case (opcode)
            7'b0010011: begin
                if (funct3 == 3'b000) begin // addi
                    imm       = immI(inst);
                    aluOp     = aluAdd;
                    aluSrc    = srcRs1Imm;
                    regSrc    = regAlu;
                    isIllegal = 1'b0;
                end else if (funct3 == 3'b001 && inst[31:26] == 6'b0) begin // slli
                    imm       = immI(inst);
                    aluOp     = aluShiftLeft;
                    aluSrc    = srcRs1Imm;
                    regSrc    = regAlu;
                    isIllegal = 1'b0;
                end
            end
            7'b1100111: begin
                if (funct3 == 3'b000) begin // jalr
                    imm       = immI(inst);
                    aluOp     = aluAddClearLsb;
                    aluSrc    = srcRs1Imm;
                    regSrc    = regSnpc;
                    pcSrc     = pcAlu;
                    isIllegal = 1'b0;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b011) begin // sd, address from rs1 + S-imm
                    imm       = immS(inst);
                    aluOp     = aluAdd;
                    aluSrc    = srcRs1Imm;
                    isStore   = 1'b1;
                    isIllegal = 1'b0;
                end
            end
            7'b0010111: begin // auipc
                imm       = immU(inst);
                aluOp     = aluAdd;
                aluSrc    = srcImmPc;
                regSrc    = regAlu;
                isIllegal = 1'b0;
            end
            7'b0110111: begin // lui
                imm       = immU(inst);
                regSrc    = regImm;
                isIllegal = 1'b0;
            end
            7'b1101111: begin // jal
                imm       = immJ(inst);
                aluOp     = aluAdd;
                aluSrc    = srcImmPc;
                regSrc    = regSnpc;
                pcSrc     = pcAlu;
                isIllegal = 1'b0;
            end
            7'b1110011: begin
                if (inst == 32'h0010_0073) begin // ebreak, exact word only
                    isBreak   = 1'b1;
                    isIllegal = 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps
`include "rvCoreConsts.svh"

module regFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1,
    input  logic [$clog2(`REG_COUNT)-1:0] rs2,
    output logic [`XLEN-1:0]              rs1Data,
    output logic [`XLEN-1:0]              rs2Data,
    input  logic                          writeEnable,
    input  logic [$clog2(`REG_COUNT)-1:0] rd,
    input  logic [`XLEN-1:0]              writeData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin // x0 writes dropped
            regs[rd] <= writeData;
        end
    end

    // async read ports, x0 storage stays zero
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // x0 reads zero on both ports whatever was written before
    x0ReadsZero: assert property (
        @(posedge clk) disable iff (reset)
        (rs1 == '0 |-> rs1Data == '0) and (rs2 == '0 |-> rs2Data == '0)
    );

endmodule

/* hdl/rvCoreConsts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// data path and address width
`define XLEN 64

// architectural integer registers, x0 included
`define REG_COUNT 32

// credits held by the core after reset, also the ceiling
`define STORE_CREDITS 4

// first fetch address
`define RESET_PC 64'h0000_0000_8000_0000

`endif

/* hdl/rvCorePkg.sv */
package rvCorePkg;

    // alu operation
    typedef enum logic [2:0] {
        aluNone        = 3'b000,
        aluAdd         = 3'b001,
        aluAddClearLsb = 3'b010, // jalr target
        aluShiftLeft   = 3'b011
    } aluOpT;

    // operand pair feeding the alu
    typedef enum logic [2:0] {
        srcRs1Rs2 = 3'b000,
        srcRs1Imm = 3'b001,
        srcImmPc  = 3'b100 // auipc and jal
    } aluSrcT;

    // writeback source for rd
    typedef enum logic [2:0] {
        regNone = 3'b000, // no register write
        regAlu  = 3'b001,
        regSnpc = 3'b011, // link value
        regImm  = 3'b100
    } regSrcT;

    // next pc source
    typedef enum logic {
        pcSnpc = 1'b0,
        pcAlu  = 1'b1
    } pcSrcT;

endpackage

/* hdl/rvCoreTop.sv */
`timescale 1ns/1ps
`include "rvCoreConsts.svh"

module rvCoreTop (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] pc,
    input  logic [31:0]      inst,
    output logic             storeValid,
    output logic [`XLEN-1:0] storeAddr,
    output logic [`XLEN-1:0] storeData,
    input  logic             storeCredit,
    output logic             halted,
    output logic             illegal
);
    import rvCorePkg::*;

    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm;
    aluOpT            aluOp;
    aluSrcT           aluSrc;
    regSrcT           regSrc;
    pcSrcT            pcSrc;
    logic             isStore;
    logic             isBreak;
    logic             isIllegal;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] snpc;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] writeData;
    logic             stall;
    logic             retire;

    assign snpc   = pc + `XLEN'd4;
    assign nextPc = (pcSrc == pcAlu) ? aluResult : snpc;
    assign retire = !halted && !stall; // one instruction per such cycle

    always_comb begin
        case (regSrc)
            regAlu:  writeData = aluResult;
            regSnpc: writeData = snpc;
            regImm:  writeData = imm;
            default: writeData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `RESET_PC;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (retire) begin
            pc <= nextPc;
            if (isBreak || isIllegal) halted <= 1'b1; // sticky until reset
            if (isIllegal) illegal <= 1'b1;
        end
    end

    instDecoder decoder0 (.inst, .rs1, .rs2, .rd, .imm, .aluOp, .aluSrc, .regSrc, .pcSrc,
                          .isStore, .isBreak, .isIllegal);

    regFile regs0 (.clk, .reset, .rs1, .rs2, .rs1Data, .rs2Data,
                   .writeEnable(retire && regSrc != regNone), .rd, .writeData);

    aluExec alu0 (.aluOp, .aluSrc, .rs1Data, .rs2Data, .imm, .pc, .result(aluResult));

    // sd address comes out of the alu as rs1 + S-imm
    storeCreditPort store0 (.clk, .reset, .storeRequest(isStore), .halted,
                            .address(aluResult), .data(rs2Data), .storeCredit,
                            .storeValid, .storeAddr, .storeData, .stall);

    pcAligned: assert property (@(posedge clk) disable iff (reset) !halted |-> pc[1:0] == 2'b00);

endmodule

/* hdl/storeCreditPort.sv */
`timescale 1ns/1ps
`include "rvCoreConsts.svh"

module storeCreditPort (
    input  logic             clk,
    input  logic             reset,
    input  logic             storeRequest,
    input  logic             halted,
    input  logic [`XLEN-1:0] address,
    input  logic [`XLEN-1:0] data,
    input  logic             storeCredit,
    output logic             storeValid,
    output logic [`XLEN-1:0] storeAddr,
    output logic [`XLEN-1:0] storeData,
    output logic             stall
);

    localparam int CntW = $clog2(`STORE_CREDITS + 1);

    logic [CntW-1:0] count;
    logic            noCredit;

    assign noCredit = (count == '0);

    // a store only leaves while a credit is held
    assign storeValid = storeRequest && !halted && !noCredit;
    assign stall      = storeRequest && noCredit;
    assign storeAddr  = address;
    assign storeData  = data;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CntW'(`STORE_CREDITS);
        end else begin
            case ({storeValid, storeCredit})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count; // both or neither cancel out
            endcase
        end
    end

    // receiver never returns more credits than it was given
    creditCeiling: assert property (
        @(posedge clk) disable iff (reset) count <= CntW'(`STORE_CREDITS)
    );

endmodule
